//--- rtl/display_ctrl.sv
module display_ctrl (
  input  logic                      cfg_clk,
  input  logic                      arst_n,
  input  logic                      init_end,   // card ready level
  input  logic                      reload,     // new image request
  input  logic                      rd_busy,    // sd controller busy level
  output logic                      rd_en,      // one-cycle read request
  output display_pkg::sector_addr_t rd_addr,
  output logic                      fb_clear,   // rewinds buffer write pointer
  output logic                      load_done,
  output logic                      display_en
);
  import display_pkg::*;

  typedef enum logic [2:0] {
    wait_init,
    start_load,
    issue,
    wait_busy_hi,
    wait_busy_lo,
    showing
  } ctrl_state_t;

  ctrl_state_t             state;
  logic [SECTOR_IDX_W-1:0] sector_idx;     // sector within the image
  logic                    last_sector;

  assign last_sector = (sector_idx == SECTOR_IDX_W'(IMG_SECTORS - 1));

  always_ff @(posedge cfg_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state      <= wait_init;
      sector_idx <= '0;
      rd_addr    <= '0;
    end
    else
    begin
      case (state)
        wait_init:
          if (init_end)
            state <= start_load;
        start_load:
        begin
          sector_idx <= '0;
          rd_addr    <= IMG_BASE_SECTOR;   // first sector of the image
          state      <= issue;
        end
        issue:
          state <= wait_busy_hi;           // rd_en high for this cycle only
        wait_busy_hi:
          if (rd_busy)
            state <= wait_busy_lo;
        wait_busy_lo:
          if (!rd_busy)
          begin
            if (last_sector)
              state <= showing;
            else
            begin
              sector_idx <= sector_idx + 1'b1;
              rd_addr    <= IMG_BASE_SECTOR + sector_addr_t'(sector_idx) + 32'd1;
              state      <= issue;
            end
          end
        showing:
          if (reload)
            state <= start_load;           // drops display, reloads image
        default:
          state <= wait_init;
      endcase
    end
  end

  // outputs decoded straight from the state register
  assign fb_clear   = (state == start_load);
  assign rd_en      = (state == issue);
  assign load_done  = (state == showing);
  assign display_en = (state == showing); // low for the whole load

endmodule

//--- rtl/display_pkg.sv
package display_pkg;

  // horizontal timing, in clocks
  localparam int H_ACTIVE = 32;
  localparam int H_FRONT  = 2;
  localparam int H_SYNC   = 4;
  localparam int H_BACK   = 2;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK; // 40

  // vertical timing, in lines
  localparam int V_ACTIVE = 16;
  localparam int V_FRONT  = 1;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 1;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK; // 20

  localparam int FRAME_PIXELS = H_ACTIVE * V_ACTIVE; // 512 words per image
  localparam int FB_ADDR_W    = $clog2(FRAME_PIXELS);

  localparam int SECTOR_WORDS = 256;                 // 16-bit words per sector
  localparam int IMG_SECTORS  = FRAME_PIXELS / SECTOR_WORDS;
  localparam int SECTOR_IDX_W = (IMG_SECTORS > 1) ? $clog2(IMG_SECTORS) : 1;

  typedef logic [15:0]          pixel_565_t;   // r5 g6 b5
  typedef logic [7:0]           chan8_t;
  typedef logic [31:0]          sector_addr_t;
  typedef logic [FB_ADDR_W-1:0] fb_addr_t;
  typedef logic [5:0]           coord_x_t;     // covers H_TOTAL
  typedef logic [4:0]           coord_y_t;     // covers V_TOTAL

  localparam sector_addr_t IMG_BASE_SECTOR = 32'd1000; // image start on card

endpackage

//--- rtl/frame_buffer.sv
module frame_buffer (
  input  logic                    cfg_clk,
  input  logic                    arst_n,
  input  logic                    fb_clear,   // restart writing at word 0
  input  logic                    wr_strobe,  // one word per strobe
  input  display_pkg::pixel_565_t wr_data,
  input  display_pkg::fb_addr_t   rd_index,
  output display_pkg::pixel_565_t rd_pixel    // one cycle after rd_index
);
  import display_pkg::*;

  pixel_565_t           mem [FRAME_PIXELS];
  logic [FB_ADDR_W:0]   wr_ptr;     // one extra bit to hold FRAME_PIXELS
  logic                 wr_full;
  logic                 wr_ok;

  assign wr_full = (wr_ptr == (FB_ADDR_W + 1)'(FRAME_PIXELS));
  assign wr_ok   = wr_strobe && !wr_full && !fb_clear; // extra words dropped

  // write pointer, saturates at the end of the image
  always_ff @(posedge cfg_clk or negedge arst_n)
  begin
    if (!arst_n)
      wr_ptr <= '0;
    else if (fb_clear)
      wr_ptr <= '0;
    else if (wr_ok)
      wr_ptr <= wr_ptr + 1'b1;
  end

  always_ff @(posedge cfg_clk)
  begin
    if (wr_ok)
      mem[wr_ptr[FB_ADDR_W-1:0]] <= wr_data;
  end

  // registered read port
  always_ff @(posedge cfg_clk)
  begin
    rd_pixel <= mem[rd_index];
  end

endmodule

//--- rtl/image_display_top.sv
module image_display_top (
  input  logic                      cfg_clk,
  input  logic                      arst_n,
  input  logic                      init_end,    // sd card ready
  input  logic                      reload,      // load a new image
  input  logic                      rd_busy,
  input  logic                      rd_data_en,  // one strobe per word
  input  display_pkg::pixel_565_t   rd_data,
  output logic                      rd_en,
  output display_pkg::sector_addr_t rd_addr,
  output logic                      load_done,
  output logic                      vs_out,
  output logic                      hs_out,
  output logic                      de_out,
  output display_pkg::chan8_t       r_out,
  output display_pkg::chan8_t       g_out,
  output display_pkg::chan8_t       b_out
);
  import display_pkg::*;

  logic       fb_clear;
  logic       display_en;
  logic       hsync_raw, vsync_raw, active_raw;  // straight from the counters
  fb_addr_t   rd_index;
  pixel_565_t fb_pixel;

  display_ctrl display_ctrl_i (
    .cfg_clk    (cfg_clk),
    .arst_n     (arst_n),
    .init_end   (init_end),
    .reload     (reload),
    .rd_busy    (rd_busy),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .fb_clear   (fb_clear),
    .load_done  (load_done),
    .display_en (display_en)
  );

  frame_buffer frame_buffer_i (
    .cfg_clk   (cfg_clk),
    .arst_n    (arst_n),
    .fb_clear  (fb_clear),
    .wr_strobe (rd_data_en),   // sd words go straight in
    .wr_data   (rd_data),
    .rd_index  (rd_index),
    .rd_pixel  (fb_pixel)
  );

  video_timing video_timing_i (
    .cfg_clk    (cfg_clk),
    .arst_n     (arst_n),
    .display_en (display_en),
    .hsync      (hsync_raw),
    .vsync      (vsync_raw),
    .active     (active_raw),
    .rd_index   (rd_index)
  );

  pixel_formatter pixel_formatter_i (
    .cfg_clk   (cfg_clk),
    .arst_n    (arst_n),
    .hsync_in  (hsync_raw),
    .vsync_in  (vsync_raw),
    .active_in (active_raw),
    .pixel     (fb_pixel),
    .hs_out    (hs_out),
    .vs_out    (vs_out),
    .de_out    (de_out),
    .r_out     (r_out),
    .g_out     (g_out),
    .b_out     (b_out)
  );

endmodule

//--- rtl/pixel_formatter.sv
module pixel_formatter (
  input  logic                    cfg_clk,
  input  logic                    arst_n,
  input  logic                    hsync_in,
  input  logic                    vsync_in,
  input  logic                    active_in,
  input  display_pkg::pixel_565_t pixel,      // buffer output, 1 cycle late
  output logic                    hs_out,
  output logic                    vs_out,
  output logic                    de_out,
  output display_pkg::chan8_t     r_out,
  output display_pkg::chan8_t     g_out,
  output display_pkg::chan8_t     b_out
);
  import display_pkg::*;

  logic   hs_d, vs_d, de_d;   // aligned with the buffer read
  chan8_t r_exp, g_exp, b_exp;

  // repeat top bits so full scale maps to 255
  assign r_exp = {pixel[15:11], pixel[15:13]};
  assign g_exp = {pixel[10:5],  pixel[10:9]};
  assign b_exp = {pixel[4:0],   pixel[4:2]};

  always_ff @(posedge cfg_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      {hs_d, vs_d, de_d}       <= 3'b000;
      {hs_out, vs_out, de_out} <= 3'b000;
      r_out <= '0;
      g_out <= '0;
      b_out <= '0;
    end
    else
    begin
      {hs_d, vs_d, de_d}       <= {hsync_in, vsync_in, active_in};
      {hs_out, vs_out, de_out} <= {hs_d, vs_d, de_d};
      r_out <= de_d ? r_exp : '0;        // black outside active video
      g_out <= de_d ? g_exp : '0;
      b_out <= de_d ? b_exp : '0;
    end
  end

endmodule

//--- rtl/video_timing.sv
module video_timing (
  input  logic                  cfg_clk,
  input  logic                  arst_n,
  input  logic                  display_en,  // low holds the frame origin
  output logic                  hsync,       // active high
  output logic                  vsync,       // active high
  output logic                  active,
  output display_pkg::fb_addr_t rd_index     // row-major pixel index
);
  import display_pkg::*;

  coord_x_t h_cnt;
  coord_y_t v_cnt;
  logic     h_last;
  logic     v_last;
  logic     h_sync_win;
  logic     v_sync_win;
  logic     in_active;
  fb_addr_t pix_index;

  assign h_last = (h_cnt == coord_x_t'(H_TOTAL - 1));
  assign v_last = (v_cnt == coord_y_t'(V_TOTAL - 1));

  // sync windows sit after the front porches
  assign h_sync_win = (h_cnt >= coord_x_t'(H_ACTIVE + H_FRONT)) &&
                      (h_cnt <  coord_x_t'(H_ACTIVE + H_FRONT + H_SYNC));
  assign v_sync_win = (v_cnt >= coord_y_t'(V_ACTIVE + V_FRONT)) &&
                      (v_cnt <  coord_y_t'(V_ACTIVE + V_FRONT + V_SYNC));

  assign in_active = (h_cnt < coord_x_t'(H_ACTIVE)) && (v_cnt < coord_y_t'(V_ACTIVE));
  assign pix_index = in_active ? fb_addr_t'(v_cnt * H_ACTIVE + h_cnt) : '0;

  // free-running counters while the display is enabled
  always_ff @(posedge cfg_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      h_cnt <= '0;
      v_cnt <= '0;
    end
    else if (!display_en)
    begin
      h_cnt <= '0;                        // park at the origin
      v_cnt <= '0;
    end
    else if (h_last)
    begin
      h_cnt <= '0;
      v_cnt <= v_last ? '0 : v_cnt + 1'b1;
    end
    else
      h_cnt <= h_cnt + 1'b1;
  end

  // syncs, active and index leave on the same edge
  always_ff @(posedge cfg_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      hsync    <= 1'b0;
      vsync    <= 1'b0;
      active   <= 1'b0;
      rd_index <= '0;
    end
    else
    begin
      hsync    <= display_en && h_sync_win;
      vsync    <= display_en && v_sync_win;
      active   <= display_en && in_active;
      rd_index <= pix_index;
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the image display testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_image_display -f src.f

out=$(./obj_dir/Vtb_image_display)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
  exit 0
else
  exit 1
fi

//--- src.f
rtl/display_pkg.sv
rtl/display_ctrl.sv
rtl/frame_buffer.sv
rtl/video_timing.sv
rtl/pixel_formatter.sv
rtl/image_display_top.sv
verification/sd_sector_model.sv
verification/tb_image_display.sv

//--- verification/sd_sector_model.sv
module sd_sector_model (
  input  logic                      cfg_clk,
  input  logic                      rd_en,       // one-cycle sector request
  input  display_pkg::sector_addr_t rd_addr,
  input  logic [3:0]                rnd,         // fresh random bits each cycle
  output logic                      rd_busy,
  output logic                      rd_data_en,
  output display_pkg::pixel_565_t   rd_data
);
  import display_pkg::*;

  pixel_565_t image [FRAME_PIXELS];   // card contents, filled by the testbench
  int         base;
  int         word;

  initial
  begin
    rd_busy    <= 1'b0;
    rd_data_en <= 1'b0;
    rd_data    <= '0;
    forever
    begin
      @(posedge cfg_clk);
      if (rd_en)
      begin
        // sector offset in the image, stray addresses wrap
        base = int'((rd_addr - IMG_BASE_SECTOR) % 32'(IMG_SECTORS)) * SECTOR_WORDS;
        repeat (int'(rnd[2:0]) + 1) @(posedge cfg_clk);   // access delay 1..8
        rd_busy <= 1'b1;
        word = 0;
        while (word < SECTOR_WORDS)
        begin
          @(posedge cfg_clk);
          if (rnd[3])
            rd_data_en <= 1'b0;                  // idle gap
          else
          begin
            rd_data_en <= 1'b1;
            rd_data    <= image[base + word];
            word++;
          end
        end
        @(posedge cfg_clk);
        rd_data_en <= 1'b0;
        rd_busy    <= 1'b0;                      // sector finished
      end
    end
  end

endmodule

//--- verification/tb_image_display.sv
module tb_image_display;
  import display_pkg::*;

  localparam int WAIT_LIMIT = 5000;   // cycles, above one load or two frames

  typedef enum int {ev_loaded, ev_unloaded, ev_frames, ev_vsync} wait_ev_t;

  logic         cfg_clk = 1'b0;
  logic         arst_n, init_end, reload;
  logic         rd_busy, rd_data_en;
  pixel_565_t   rd_data;
  logic         rd_en, load_done, vs_out, hs_out, de_out;
  sector_addr_t rd_addr;
  chan8_t       r_out, g_out, b_out;

  logic [31:0]  img_lfsr = 32'hf1ac_21ec;   // image stream
  logic [31:0]  gap_lfsr = 32'hf1ac_21ec;   // sd timing stream
  logic [3:0]   gap_rnd = '0;
  logic [3:0]   gap_bits;
  pixel_565_t   exp_img [FRAME_PIXELS];     // reference copy of the image

  int val_errs = 0;
  int proto_errs = 0;
  int timeouts = 0;
  int req_n = 0;                            // requests in this load
  int busy_falls = 0;                       // finished sectors in this load
  int quiet = 0;                            // cycles since load_done went low
  int hs_len = 0;
  int hs_gap = 0;
  int vs_len = 0;
  int de_len = 0;
  int runs = 0;
  int pix_n = 0;
  int frames_done = 0;
  bit hs_seen = 1'b0;
  logic hs_q = 1'b0;
  logic vs_q = 1'b0;
  logic done_q = 1'b0;
  logic busy_q = 1'b0;

  always #4 cfg_clk = ~cfg_clk;   // 8 unit period

  image_display_top image_display_top_i (
    .cfg_clk(cfg_clk), .arst_n(arst_n), .init_end(init_end), .reload(reload),
    .rd_busy(rd_busy), .rd_data_en(rd_data_en), .rd_data(rd_data),
    .rd_en(rd_en), .rd_addr(rd_addr), .load_done(load_done),
    .vs_out(vs_out), .hs_out(hs_out), .de_out(de_out),
    .r_out(r_out), .g_out(g_out), .b_out(b_out)
  );

  sd_sector_model sd_sector_model_i (
    .cfg_clk(cfg_clk), .rd_en(rd_en), .rd_addr(rd_addr), .rnd(gap_rnd),
    .rd_busy(rd_busy), .rd_data_en(rd_data_en), .rd_data(rd_data)
  );

  // galois form of x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // top bits repeated into the low bits
  function automatic chan8_t chan_from5(input logic [4:0] v);
    return {v, v[4:2]};
  endfunction

  function automatic chan8_t chan_from6(input logic [5:0] v);
    return {v, v[5:4]};
  endfunction

  task automatic check_sector(input string name, input sector_addr_t exp, input sector_addr_t act);
    if (exp !== act)
    begin
      $display("FAIL %s expected %0d actual %0d", name, exp, act);
      val_errs++;
    end
  endtask

  task automatic check_pixel(input string name, input chan8_t exp, input chan8_t act);
    if (exp !== act)
    begin
      $display("FAIL %s expected %02h actual %02h", name, exp, act);
      val_errs++;
    end
  endtask

  task automatic check_count(input string name, input coord_x_t exp, input coord_x_t act);
    if (exp !== act)
    begin
      $display("FAIL %s expected %0d actual %0d", name, exp, act);
      val_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("FAIL %s expected %b actual %b", name, exp, act);
      val_errs++;
    end
  endtask

  // new card image, 16 lfsr steps per word
  task automatic gen_image();
    pixel_565_t w;
    for (int i = 0; i < FRAME_PIXELS; i++)
    begin
      w = '0;
      for (int b = 0; b < 16; b++)
      begin
        img_lfsr = lfsr_step(img_lfsr);
        w = {w[14:0], img_lfsr[0]};
      end
      exp_img[i] = w;
      sd_sector_model_i.image[i] = w;
    end
  endtask

  function automatic bit reached(input wait_ev_t ev, input int mark);
    case (ev)
      ev_loaded:   return load_done;
      ev_unloaded: return !load_done;
      ev_frames:   return frames_done >= mark;
      default:     return vs_out;
    endcase
  endfunction

  task automatic wait_until(input wait_ev_t ev, input int mark, input string what, output bit ok);
    int t;
    t = 0;
    while (!reached(ev, mark) && t < WAIT_LIMIT)
    begin
      @(posedge cfg_clk);
      t++;
    end
    ok = reached(ev, mark);
    if (!ok)
    begin
      $display("timed out waiting for %s", what);
      timeouts++;
    end
  endtask

  task automatic run_test();
    bit ok;
    repeat (30) @(posedge cfg_clk);   // card still busy, no request allowed
    init_end <= 1'b1;
    wait_until(ev_loaded, 0, "first load_done", ok);
    if (!ok) return;
    wait_until(ev_frames, frames_done + 2, "two frames of the first image", ok);
    if (!ok) return;
    wait_until(ev_vsync, 0, "vertical sync before reload", ok);
    if (!ok) return;
    gen_image();                      // no de in vsync, old image no longer compared
    reload <= 1'b1;
    @(posedge cfg_clk);
    reload <= 1'b0;
    wait_until(ev_unloaded, 0, "load_done to fall after reload", ok);
    if (!ok) return;
    wait_until(ev_loaded, 0, "load_done after reload", ok);
    if (!ok) return;
    wait_until(ev_frames, frames_done + 1, "a frame of the new image", ok);
  endtask

  always @(posedge cfg_clk)
  begin
    for (int k = 0; k < 4; k++)
    begin
      gap_lfsr = lfsr_step(gap_lfsr);
      gap_bits[k] = gap_lfsr[0];
    end
    gap_rnd <= gap_bits;
  end

  // output monitor, samples the values from before the edge
  always @(posedge cfg_clk)
  begin
    if (arst_n)
    begin
      if (rd_en)
      begin
        if (!init_end)
        begin
          $display("rd_en was raised before init_end");
          proto_errs++;
        end
        check_sector("sector address", IMG_BASE_SECTOR + sector_addr_t'(req_n), rd_addr);
        check_count("requests ahead of finished sectors",
                    coord_x_t'(busy_falls), coord_x_t'(req_n));
        check_flag("rd_busy at request", 1'b0, rd_busy);
        req_n++;
      end
      if (busy_q && !rd_busy)
        busy_falls++;
      if (load_done && !done_q)
        check_count("sectors before load_done", coord_x_t'(IMG_SECTORS), coord_x_t'(busy_falls));
      if (load_done)
      begin
        req_n = 0;
        busy_falls = 0;
      end
      if (!de_out)
      begin
        check_pixel("red in blanking", 8'h00, r_out);
        check_pixel("green in blanking", 8'h00, g_out);
        check_pixel("blue in blanking", 8'h00, b_out);
      end
      quiet = load_done ? 0 : quiet + 1;
      if (quiet > 3)                  // past the output pipeline
      begin
        check_flag("hs_out without image", 1'b0, hs_out);
        check_flag("vs_out without image", 1'b0, vs_out);
        check_flag("de_out without image", 1'b0, de_out);
      end
      if (!load_done)
      begin
        hs_len = 0;
        hs_gap = 0;
        hs_seen = 1'b0;
        vs_len = 0;
        de_len = 0;
        runs = 0;
        pix_n = 0;
      end
      else
      begin
        if (hs_out)
          hs_len++;
        else if (hs_len != 0)
        begin
          check_count("hsync width", coord_x_t'(H_SYNC), coord_x_t'(hs_len));
          hs_len = 0;
        end
        if (hs_out && !hs_q)
        begin
          if (hs_seen)
            check_count("hsync period", coord_x_t'(H_TOTAL), coord_x_t'(hs_gap));
          hs_seen = 1'b1;
          hs_gap = 0;
        end
        hs_gap++;
        if (vs_out)
          vs_len++;
        else if (vs_len != 0)
        begin
          check_count("vsync lines", coord_x_t'(V_SYNC), coord_x_t'(vs_len / H_TOTAL));
          check_flag("vsync whole lines", 1'b1, vs_len % H_TOTAL == 0);
          vs_len = 0;
        end
        if (de_out)
        begin
          check_pixel($sformatf("red %0d", pix_n),
                      chan_from5(exp_img[pix_n % FRAME_PIXELS][15:11]), r_out);
          check_pixel($sformatf("green %0d", pix_n),
                      chan_from6(exp_img[pix_n % FRAME_PIXELS][10:5]), g_out);
          check_pixel($sformatf("blue %0d", pix_n),
                      chan_from5(exp_img[pix_n % FRAME_PIXELS][4:0]), b_out);
          de_len++;
          pix_n++;
        end
        else if (de_len != 0)
        begin
          check_count("de run length", coord_x_t'(H_ACTIVE), coord_x_t'(de_len));
          de_len = 0;
          runs++;
        end
        if (vs_out && !vs_q)          // frame ends, active area is above
        begin
          check_count("de runs per frame", coord_x_t'(V_ACTIVE), coord_x_t'(runs));
          check_flag("full frame of pixels", 1'b1, pix_n == FRAME_PIXELS);
          runs = 0;
          pix_n = 0;
          frames_done <= frames_done + 1;
        end
      end
    end
    hs_q = hs_out;
    vs_q = vs_out;
    done_q = load_done;
    busy_q = rd_busy;
  end

  initial
  begin
    arst_n   <= 1'b0;
    init_end <= 1'b0;
    reload   <= 1'b0;
    gen_image();
    repeat (10) @(posedge cfg_clk);
    arst_n <= 1'b1;
    run_test();
    $display("value errors %0d, protocol errors %0d, timeouts %0d",
             val_errs, proto_errs, timeouts);
    if (val_errs == 0 && proto_errs == 0 && timeouts == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule
